// File: all.f
+incdir+tests
hdl/backend_pkg.sv
hdl/instruction_decoder.sv
hdl/single_cycle_execute.sv
hdl/dcache_data_stage.sv
hdl/writeback_stage.sv
hdl/vector_core_backend.sv
tests/backend_tb.sv

// File: Bender.yml
package:
  name: vector_core_backend

sources:
  - files:
      - hdl/backend_pkg.sv
      - hdl/instruction_decoder.sv
      - hdl/single_cycle_execute.sv
      - hdl/dcache_data_stage.sv
      - hdl/writeback_stage.sv
      - hdl/vector_core_backend.sv
  - target: test
    include_dirs:
      - tests
    files:
      - tests/backend_tb.sv

// File: tests/backend_model.svh
// Memory image and reference functions for arithmetic, load, block and rollback results
`ifndef BACKEND_MODEL_SVH
`define BACKEND_MODEL_SVH

// Stored word for a line and lane, every address bit mixed in
function automatic logic [DATA_WIDTH-1:0] image_word(input int line, input int lane);
	logic [31:0] addr;
	addr = line * num_lanes + lane;
	return ((addr + 1) * 32'h9e37_79b9) ^ (addr << 20);
endfunction

// Flat line image, lane 0 in the low bits
function automatic logic [vec_bits-1:0] line_image(input int line);
	logic [vec_bits-1:0] img;
	for (int lane = 0; lane < num_lanes; lane++)
		img[lane*DATA_WIDTH +: DATA_WIDTH] = image_word(line, lane);
	return img;
endfunction

// Byte k of a stored word, byte 0 is the most significant
function automatic logic [7:0] stored_byte(input logic [31:0] word, input int k);
	return word[31 - 8*k -: 8];
endfunction

// Big-endian storage to value order
function automatic logic [31:0] swap_bytes(input logic [31:0] word);
	return {stored_byte(word, 3), stored_byte(word, 2), stored_byte(word, 1),
		stored_byte(word, 0)};
endfunction

// Lane by lane arithmetic
function automatic logic [vec_bits-1:0] alu_ref(input logic [3:0] op,
	input logic [vec_bits-1:0] a, input logic [vec_bits-1:0] b);
	logic [DATA_WIDTH-1:0] x;
	logic [DATA_WIDTH-1:0] y;
	logic [DATA_WIDTH-1:0] r;
	logic [vec_bits-1:0] out;
	for (int lane = 0; lane < num_lanes; lane++)
	begin
		x = a[lane*DATA_WIDTH +: DATA_WIDTH];
		y = b[lane*DATA_WIDTH +: DATA_WIDTH];
		case (op)
			ALU_ADD: r = x + y;
			ALU_SUB: r = x - y;
			ALU_AND: r = x & y;
			ALU_OR: r = x | y;
			ALU_XOR: r = x ^ y;
			// Shift counts come from the low 5 bits
			ALU_SHL: r = x << y[4:0];
			ALU_SHR: r = x >> y[4:0];
			ALU_MOVE: r = y;
			// Branch has no result to write
			default: r = '0;
		endcase
		out[lane*DATA_WIDTH +: DATA_WIDTH] = r;
	end
	return out;
endfunction

// Scalar load, addressed word 0 sits in the top lane of the line
function automatic logic [DATA_WIDTH-1:0] load_ref(input logic [2:0] kind,
	input logic [vec_bits-1:0] line, input logic [DATA_WIDTH-1:0] addr);
	logic [31:0] word;
	logic [7:0] b;
	logic [15:0] h;
	int wi;
	int ho;
	wi = int'((addr >> 2) % num_lanes);
	word = line[(num_lanes - 1 - wi) * DATA_WIDTH +: DATA_WIDTH];
	b = stored_byte(word, int'(addr[1:0]));
	// Halfword at the aligned pair, lower address is the low byte
	ho = addr[1] ? 2 : 0;
	h = {stored_byte(word, ho + 1), stored_byte(word, ho)};
	case (kind)
		MEM_B: return {24'd0, b};
		MEM_BX: return {{24{b[7]}}, b};
		MEM_S: return {16'd0, h};
		MEM_SX: return {{16{h[15]}}, h};
		default: return swap_bytes(word);
	endcase
endfunction

// Whole line with each lane swapped in place
function automatic logic [vec_bits-1:0] block_ref(input logic [vec_bits-1:0] line);
	logic [vec_bits-1:0] out;
	for (int lane = 0; lane < num_lanes; lane++)
		out[lane*DATA_WIDTH +: DATA_WIDTH] = swap_bytes(line[lane*DATA_WIDTH +: DATA_WIDTH]);
	return out;
endfunction

// Rollback of an arithmetic instruction, target returned through pc
function automatic logic rollback_ref(input logic [3:0] op, input logic [REG_BITS-1:0] dreg,
	input logic [DATA_WIDTH-1:0] a0, input logic [DATA_WIDTH-1:0] b0,
	input logic [DATA_WIDTH-1:0] r0, output logic [DATA_WIDTH-1:0] pc);
	pc = '0;
	// PC write redirects to its own result
	if (op != ALU_BNZ && dreg == REG_PC)
	begin
		pc = r0;
		return 1'b1;
	end
	// Taken branch
	if (op == ALU_BNZ && a0 != '0)
	begin
		pc = b0;
		return 1'b1;
	end
	return 1'b0;
endfunction

`endif

// File: tests/backend_tb.sv
// Backend testbench with clock, reset, line fill, random issue, expected tables and checker
`timescale 1ns/1ps

module backend_tb import backend_pkg::*; ();

	localparam int num_lanes = 4;
	localparam int num_lines = 16;
	localparam int vec_bits = num_lanes * DATA_WIDTH;
	localparam int line_bytes = num_lanes * DATA_WIDTH / 8;
	localparam int table_size = 1024;
	localparam int num_issues = 800;

	logic clk = 1'b0;
	logic reset;
	logic issue_valid;
	logic [THREAD_BITS-1:0] issue_thread;
	instr_word_u issue_instr;
	logic [vec_bits-1:0] issue_operand_a;
	logic [vec_bits-1:0] issue_operand_b;
	logic [num_lanes-1:0] issue_mask;
	logic fill_en;
	logic [$clog2(num_lines)-1:0] fill_line;
	logic [vec_bits-1:0] fill_data;
	logic wb_en;
	logic [THREAD_BITS-1:0] wb_thread;
	logic wb_is_vector;
	logic [vec_bits-1:0] wb_value;
	logic [num_lanes-1:0] wb_mask;
	logic [REG_BITS-1:0] wb_reg;
	logic wb_rollback_en;
	logic [THREAD_BITS-1:0] wb_rollback_thread;
	logic [DATA_WIDTH-1:0] wb_rollback_pc;

	// Expected outputs, indexed by the edge after which they hold
	logic exp_wb_en [table_size];
	logic [THREAD_BITS-1:0] exp_wb_thread [table_size];
	logic exp_wb_vector [table_size];
	logic [vec_bits-1:0] exp_wb_value [table_size];
	logic [num_lanes-1:0] exp_wb_mask [table_size];
	logic [REG_BITS-1:0] exp_wb_reg [table_size];
	logic exp_rb_en [table_size];
	logic [THREAD_BITS-1:0] exp_rb_thread [table_size];
	logic [DATA_WIDTH-1:0] exp_rb_pc [table_size];

	// Contents the memory was filled with
	logic [vec_bits-1:0] image [num_lines];

	int edge_cnt = 0;
	int checked_edge = 0;
	int first_issue_edge = table_size;
	int value_errors = 0;
	int timeout_errors = 0;

	`include "backend_model.svh"

	vector_core_backend #(
		.num_lanes(num_lanes),
		.num_lines(num_lines)
	) dut_i (
		.*
	);

	always #2 clk = ~clk;

	// Edge number, read before update by the driver at the same edge
	always @(posedge clk)
		edge_cnt <= edge_cnt + 1;

	task automatic check_signal(input string name, input logic [vec_bits-1:0] got,
		input logic [vec_bits-1:0] expected);
		assert (got === expected)
		else
		begin
			$display("ERROR %0t %s got %0h expected %0h", $time, name, got, expected);
			value_errors++;
		end
	endtask

	// Drives one random issue for sampling edge s and records its expected results
	task automatic issue_random(input int s);
		logic [31:0] r;
		logic [31:0] r2;
		logic valid;
		logic [THREAD_BITS-1:0] thread;
		logic is_mem;
		logic dv;
		logic [REG_BITS-1:0] dreg;
		logic [num_lanes-1:0] mask;
		logic [3:0] op;
		logic [2:0] kind;
		logic [12:0] offset;
		logic [vec_bits-1:0] a;
		logic [vec_bits-1:0] b;
		logic [vec_bits-1:0] result;
		logic [DATA_WIDTH-1:0] addr;
		logic [DATA_WIDTH-1:0] pc;
		logic rolls;
		int li;
		r = $urandom;
		r2 = $urandom;
		valid = r[2:0] != 3'd0;
		thread = r[4:3];
		is_mem = r[5];
		dv = r[6];
		dreg = r[11:7];
		// Extra PC writes so rollbacks come often
		if (r[14:12] == 3'd0)
			dreg = REG_PC;
		mask = r[15 +: num_lanes];
		op = r2[3:0] % 4'd9;
		kind = r2[6:4] % 3'd6;
		offset = r2[31:19];
		for (int lane = 0; lane < num_lanes; lane++)
		begin
			a[lane*DATA_WIDTH +: DATA_WIDTH] = $urandom;
			b[lane*DATA_WIDTH +: DATA_WIDTH] = $urandom;
		end
		// Not-taken branches need a zero lane 0
		if (r[19])
			a[DATA_WIDTH-1:0] = '0;
		issue_valid <= valid;
		issue_thread <= thread;
		if (is_mem)
			issue_instr <= {1'b1, kind, dv, dreg, 9'd0, offset};
		else
			issue_instr <= {1'b0, op, dv, dreg, 21'd0};
		issue_operand_a <= a;
		issue_operand_b <= b;
		issue_mask <= mask;
		// Same-thread rollbacks from the two older edges kill this one
		if (!valid || (exp_rb_en[s] && exp_rb_thread[s] == thread)
			|| (exp_rb_en[s-1] && exp_rb_thread[s-1] == thread))
			return;
		exp_wb_thread[s+2] = thread;
		exp_wb_vector[s+2] = dv;
		exp_wb_reg[s+2] = dreg;
		if (is_mem)
		begin
			addr = a[DATA_WIDTH-1:0] + {{(DATA_WIDTH-13){offset[12]}}, offset};
			li = int'((addr / line_bytes) % num_lines);
			exp_wb_en[s+2] = 1'b1;
			if (kind == MEM_BLOCK)
			begin
				exp_wb_value[s+2] = block_ref(image[li]);
				exp_wb_mask[s+2] = mask;
			end
			else
			begin
				exp_wb_value[s+2] = {num_lanes{load_ref(kind, image[li], addr)}};
				exp_wb_mask[s+2] = '1;
			end
		end
		else
		begin
			result = alu_ref(op, a, b);
			rolls = rollback_ref(op, dreg, a[DATA_WIDTH-1:0], b[DATA_WIDTH-1:0],
				result[DATA_WIDTH-1:0], pc);
			// Rollback shows one cycle after sampling
			exp_rb_en[s+1] = rolls;
			exp_rb_thread[s+1] = thread;
			exp_rb_pc[s+1] = pc;
			exp_wb_en[s+2] = op != ALU_BNZ && !rolls;
			exp_wb_value[s+2] = result;
			exp_wb_mask[s+2] = mask;
		end
	endtask

	// Compare against the table in the middle of every cycle
	always @(negedge clk)
	begin
		if (edge_cnt < table_size)
		begin
			check_signal("wb_en", vec_bits'(wb_en), vec_bits'(exp_wb_en[edge_cnt]));
			check_signal("wb_rollback_en", vec_bits'(wb_rollback_en),
				vec_bits'(exp_rb_en[edge_cnt]));
			// Nothing written yet
			if (edge_cnt < first_issue_edge + 2)
				check_signal("wb_value", wb_value, '0);
			if (exp_wb_en[edge_cnt])
			begin
				check_signal("wb_thread", vec_bits'(wb_thread), vec_bits'(exp_wb_thread[edge_cnt]));
				check_signal("wb_is_vector", vec_bits'(wb_is_vector),
					vec_bits'(exp_wb_vector[edge_cnt]));
				check_signal("wb_value", wb_value, exp_wb_value[edge_cnt]);
				check_signal("wb_mask", vec_bits'(wb_mask), vec_bits'(exp_wb_mask[edge_cnt]));
				check_signal("wb_reg", vec_bits'(wb_reg), vec_bits'(exp_wb_reg[edge_cnt]));
			end
			if (exp_rb_en[edge_cnt])
			begin
				check_signal("wb_rollback_thread", vec_bits'(wb_rollback_thread),
					vec_bits'(exp_rb_thread[edge_cnt]));
				check_signal("wb_rollback_pc", vec_bits'(wb_rollback_pc),
					vec_bits'(exp_rb_pc[edge_cnt]));
			end
			checked_edge = edge_cnt;
		end
	end

	initial
	begin
		int s;
		int last_edge;
		int wait_cycles;
		foreach (exp_wb_en[k])
		begin
			exp_wb_en[k] = 1'b0;
			exp_rb_en[k] = 1'b0;
		end
		void'($urandom(32'h96fa_5def));
		reset = 1'b1;
		issue_valid = 1'b0;
		issue_thread = '0;
		issue_instr = '0;
		issue_operand_a = '0;
		issue_operand_b = '0;
		issue_mask = '0;
		fill_en = 1'b0;
		fill_line = '0;
		fill_data = '0;
		repeat (5) @(posedge clk);
		reset <= 1'b0;
		// One fill per line from the model image
		for (int line = 0; line < num_lines; line++)
		begin
			image[line] = line_image(line);
			fill_en <= 1'b1;
			fill_line <= line[$clog2(num_lines)-1:0];
			fill_data <= image[line];
			@(posedge clk);
		end
		fill_en <= 1'b0;
		s = 0;
		for (int n = 0; n < num_issues; n++)
		begin
			// Inputs set now are sampled at the next edge
			s = edge_cnt + 2;
			if (n == 0)
				first_issue_edge = s;
			issue_random(s);
			@(posedge clk);
		end
		issue_valid <= 1'b0;
		last_edge = s + 2;
		wait_cycles = 0;
		while (checked_edge < last_edge && timeout_errors == 0)
		begin
			@(posedge clk);
			wait_cycles++;
			if (wait_cycles > 20)
			begin
				$display("Timeout at %0t, last writeback was never checked", $time);
				timeout_errors++;
			end
		end
		$display("Error counts: %0d value, %0d timeout", value_errors, timeout_errors);
		if (value_errors == 0 && timeout_errors == 0)
			$display("PASS: all tests");
		else
			$display("FAIL: see errors above");
		$finish;
	end

endmodule

// File: hdl/vector_core_backend.sv
// Backend top level joining decoder, execute, data and writeback stages
`timescale 1ns/1ps

module vector_core_backend import backend_pkg::*; #(
	parameter int num_lanes = 4,
	parameter int num_lines = 16
) (
	input logic clk,
	input logic reset,

	// Issue
	input logic issue_valid,
	input logic [THREAD_BITS-1:0] issue_thread,
	input instr_word_u issue_instr,
	input logic [num_lanes*DATA_WIDTH-1:0] issue_operand_a,
	input logic [num_lanes*DATA_WIDTH-1:0] issue_operand_b,
	input logic [num_lanes-1:0] issue_mask,

	// Line fill
	input logic fill_en,
	input logic [$clog2(num_lines)-1:0] fill_line,
	input logic [num_lanes*DATA_WIDTH-1:0] fill_data,

	// Writeback and rollback
	output logic wb_en,
	output logic [THREAD_BITS-1:0] wb_thread,
	output logic wb_is_vector,
	output logic [num_lanes*DATA_WIDTH-1:0] wb_value,
	output logic [num_lanes-1:0] wb_mask,
	output logic [REG_BITS-1:0] wb_reg,
	output logic wb_rollback_en,
	output logic [THREAD_BITS-1:0] wb_rollback_thread,
	output logic [DATA_WIDTH-1:0] wb_rollback_pc
);

	// Decoder outputs
	logic id_alu_valid;
	logic id_mem_valid;
	logic [THREAD_BITS-1:0] id_thread;
	logic [3:0] id_alu_op;
	logic [2:0] id_mem_op;
	logic id_has_dest;
	logic id_dest_is_vector;
	logic [REG_BITS-1:0] id_dest_reg;
	logic [num_lanes*DATA_WIDTH-1:0] id_operand_a;
	logic [num_lanes*DATA_WIDTH-1:0] id_operand_b;
	logic [num_lanes-1:0] id_mask;
	logic [12:0] id_mem_offset;

	// Execute outputs
	logic sc_instruction_valid;
	logic [THREAD_BITS-1:0] sc_thread;
	logic sc_has_dest;
	logic sc_dest_is_vector;
	logic [REG_BITS-1:0] sc_dest_reg;
	logic [num_lanes*DATA_WIDTH-1:0] sc_result;
	logic [num_lanes-1:0] sc_mask;
	logic sc_rollback_en;
	logic [DATA_WIDTH-1:0] sc_rollback_pc;

	// Data stage outputs
	logic dd_instruction_valid;
	logic [THREAD_BITS-1:0] dd_thread;
	logic [2:0] dd_mem_op;
	logic dd_dest_is_vector;
	logic [REG_BITS-1:0] dd_dest_reg;
	logic [num_lanes-1:0] dd_mask;
	logic [DATA_WIDTH-1:0] dd_request_addr;
	logic [num_lanes*DATA_WIDTH-1:0] dd_line;

	instruction_decoder #(
		.num_lanes(num_lanes)
	) instruction_decoder_i (
		.*
	);

	single_cycle_execute #(
		.num_lanes(num_lanes)
	) single_cycle_execute_i (
		.*
	);

	dcache_data_stage #(
		.num_lanes(num_lanes),
		.num_lines(num_lines)
	) dcache_data_stage_i (
		.*
	);

	writeback_stage #(
		.num_lanes(num_lanes)
	) writeback_stage_i (
		.*
	);

endmodule

// File: hdl/writeback_stage.sv
// Load alignment and extension, block byte swap, rollback generation, writeback registers
`timescale 1ns/1ps

module writeback_stage import backend_pkg::*; #(
	parameter int num_lanes = 4
) (
	input logic clk,
	input logic reset,

	// From execute stage
	input logic sc_instruction_valid,
	input logic [THREAD_BITS-1:0] sc_thread,
	input logic sc_has_dest,
	input logic sc_dest_is_vector,
	input logic [REG_BITS-1:0] sc_dest_reg,
	input logic [num_lanes*DATA_WIDTH-1:0] sc_result,
	input logic [num_lanes-1:0] sc_mask,
	input logic sc_rollback_en,
	input logic [DATA_WIDTH-1:0] sc_rollback_pc,

	// From data stage
	input logic dd_instruction_valid,
	input logic [THREAD_BITS-1:0] dd_thread,
	input logic [2:0] dd_mem_op,
	input logic dd_dest_is_vector,
	input logic [REG_BITS-1:0] dd_dest_reg,
	input logic [num_lanes-1:0] dd_mask,
	input logic [DATA_WIDTH-1:0] dd_request_addr,
	input logic [num_lanes*DATA_WIDTH-1:0] dd_line,

	// Rollback to all stages
	output logic wb_rollback_en,
	output logic [THREAD_BITS-1:0] wb_rollback_thread,
	output logic [DATA_WIDTH-1:0] wb_rollback_pc,

	// Register write
	output logic wb_en,
	output logic [THREAD_BITS-1:0] wb_thread,
	output logic wb_is_vector,
	output logic [num_lanes*DATA_WIDTH-1:0] wb_value,
	output logic [num_lanes-1:0] wb_mask,
	output logic [REG_BITS-1:0] wb_reg
);

	localparam int word_index_bits = $clog2(num_lanes);

	logic [word_index_bits-1:0] word_index;
	logic [DATA_WIDTH-1:0] load_word;
	logic [7:0] byte_aligned;
	logic [15:0] half_aligned;
	logic [DATA_WIDTH-1:0] scalar_value;
	wire [num_lanes*DATA_WIDTH-1:0] swapped_line;

	// Only the arithmetic path can redirect a thread
	always_comb
	begin
		wb_rollback_en = 1'b0;
		wb_rollback_pc = '0;
		if (sc_instruction_valid && sc_has_dest && sc_dest_reg == REG_PC)
		begin
			// PC write goes to lane 0 of the result
			wb_rollback_en = 1'b1;
			wb_rollback_pc = sc_result[DATA_WIDTH-1:0];
		end
		else if (sc_instruction_valid && sc_rollback_en)
		begin
			wb_rollback_en = 1'b1;
			wb_rollback_pc = sc_rollback_pc;
		end
	end

	assign wb_rollback_thread = sc_thread;

	// Word 0 of the line sits in the high bits of memory order
	assign word_index = dd_request_addr[2 +: word_index_bits];
	assign load_word = dd_line[(num_lanes - 1 - word_index) * DATA_WIDTH +: DATA_WIDTH];

	// Byte 0 is the most significant byte of the stored word
	always_comb
	begin
		case (dd_request_addr[1:0])
			2'd0: byte_aligned = load_word[31:24];
			2'd1: byte_aligned = load_word[23:16];
			2'd2: byte_aligned = load_word[15:8];
			default: byte_aligned = load_word[7:0];
		endcase
	end

	// Halfword bytes come out swapped
	assign half_aligned = dd_request_addr[1] ? {load_word[7:0], load_word[15:8]}
		: {load_word[23:16], load_word[31:24]};

	always_comb
	begin
		case (dd_mem_op)
			MEM_B: scalar_value = {24'd0, byte_aligned};
			MEM_BX: scalar_value = {{24{byte_aligned[7]}}, byte_aligned};
			MEM_S: scalar_value = {16'd0, half_aligned};
			MEM_SX: scalar_value = {{16{half_aligned[15]}}, half_aligned};
			// Full word, all four bytes reversed
			default: scalar_value = {load_word[7:0], load_word[15:8], load_word[23:16],
				load_word[31:24]};
		endcase
	end

	// Block loads swap bytes in each word, lane order kept
	for (genvar w = 0; w < num_lanes; w++)
	begin : block_swap
		assign swapped_line[w*DATA_WIDTH +: DATA_WIDTH] = {dd_line[w*DATA_WIDTH +: 8],
			dd_line[w*DATA_WIDTH+8 +: 8], dd_line[w*DATA_WIDTH+16 +: 8],
			dd_line[w*DATA_WIDTH+24 +: 8]};
	end

	always_ff @(posedge clk, posedge reset)
	begin
		if (reset)
		begin
			wb_en <= 1'b0;
			wb_thread <= '0;
			wb_is_vector <= 1'b0;
			wb_value <= '0;
			wb_mask <= '0;
			wb_reg <= '0;
		end
		else if (sc_instruction_valid)
		begin
			// Rolling-back instruction never writes
			wb_en <= sc_has_dest && !wb_rollback_en;
			wb_thread <= sc_thread;
			wb_is_vector <= sc_dest_is_vector;
			wb_value <= sc_result;
			wb_mask <= sc_mask;
			wb_reg <= sc_dest_reg;
		end
		else if (dd_instruction_valid)
		begin
			wb_en <= 1'b1;
			wb_thread <= dd_thread;
			wb_is_vector <= dd_dest_is_vector;
			wb_reg <= dd_dest_reg;
			if (dd_mem_op == MEM_BLOCK)
			begin
				wb_value <= swapped_line;
				wb_mask <= dd_mask;
			end
			else
			begin
				// Scalar into every lane
				wb_value <= {num_lanes{scalar_value}};
				wb_mask <= '1;
			end
		end
		else
			wb_en <= 1'b0;
	end

endmodule

// File: hdl/dcache_data_stage.sv
// Cache-line memory with fill port, load address generation and registered line read
`timescale 1ns/1ps

module dcache_data_stage import backend_pkg::*; #(
	parameter int num_lanes = 4,
	parameter int num_lines = 16
) (
	input logic clk,
	input logic reset,

	// Line fill from outside
	input logic fill_en,
	input logic [$clog2(num_lines)-1:0] fill_line,
	input logic [num_lanes*DATA_WIDTH-1:0] fill_data,

	// From decoder
	input logic id_mem_valid,
	input logic [THREAD_BITS-1:0] id_thread,
	input logic [2:0] id_mem_op,
	input logic id_dest_is_vector,
	input logic [REG_BITS-1:0] id_dest_reg,
	input logic [num_lanes*DATA_WIDTH-1:0] id_operand_a,
	input logic [num_lanes-1:0] id_mask,
	input logic [12:0] id_mem_offset,

	// Rollback from writeback
	input logic wb_rollback_en,
	input logic [THREAD_BITS-1:0] wb_rollback_thread,

	// To writeback
	output logic dd_instruction_valid,
	output logic [THREAD_BITS-1:0] dd_thread,
	output logic [2:0] dd_mem_op,
	output logic dd_dest_is_vector,
	output logic [REG_BITS-1:0] dd_dest_reg,
	output logic [num_lanes-1:0] dd_mask,
	output logic [DATA_WIDTH-1:0] dd_request_addr,
	output logic [num_lanes*DATA_WIDTH-1:0] dd_line
);

	// Byte offset bits within a line of num_lanes words
	localparam int line_offset_bits = $clog2(num_lanes * DATA_WIDTH / 8);
	localparam int line_index_bits = $clog2(num_lines);

	logic [num_lanes*DATA_WIDTH-1:0] line_mem [num_lines];
	logic [DATA_WIDTH-1:0] request_addr;
	logic [line_index_bits-1:0] read_line;
	logic accept;

	// Lane 0 of A plus sign-extended offset
	assign request_addr = id_operand_a[DATA_WIDTH-1:0]
		+ {{(DATA_WIDTH-13){id_mem_offset[12]}}, id_mem_offset};

	// Bits above the line offset, wrapped to the memory size
	assign read_line = request_addr[line_offset_bits +: line_index_bits];

	// Same squash rule as the arithmetic path
	assign accept = id_mem_valid && !(wb_rollback_en && wb_rollback_thread == id_thread);

	// Fill write, a read at the same edge still sees the old line
	always_ff @(posedge clk)
	begin
		if (fill_en)
			line_mem[fill_line] <= fill_data;
	end

	always_ff @(posedge clk, posedge reset)
	begin
		if (reset)
		begin
			dd_instruction_valid <= 1'b0;
			dd_thread <= '0;
			dd_mem_op <= '0;
			dd_dest_is_vector <= 1'b0;
			dd_dest_reg <= '0;
			dd_mask <= '0;
			dd_request_addr <= '0;
			dd_line <= '0;
		end
		else
		begin
			dd_instruction_valid <= accept;
			dd_thread <= id_thread;
			dd_mem_op <= id_mem_op;
			dd_dest_is_vector <= id_dest_is_vector;
			dd_dest_reg <= id_dest_reg;
			dd_mask <= id_mask;
			dd_request_addr <= request_addr;
			// Synchronous line read
			dd_line <= line_mem[read_line];
		end
	end

endmodule

// File: hdl/single_cycle_execute.sv
// Per-lane arithmetic, branch resolution and execute result registers
`timescale 1ns/1ps

module single_cycle_execute import backend_pkg::*; #(
	parameter int num_lanes = 4
) (
	input logic clk,
	input logic reset,

	// From decoder
	input logic id_alu_valid,
	input logic [THREAD_BITS-1:0] id_thread,
	input logic [3:0] id_alu_op,
	input logic id_has_dest,
	input logic id_dest_is_vector,
	input logic [REG_BITS-1:0] id_dest_reg,
	input logic [num_lanes*DATA_WIDTH-1:0] id_operand_a,
	input logic [num_lanes*DATA_WIDTH-1:0] id_operand_b,
	input logic [num_lanes-1:0] id_mask,

	// Rollback from writeback
	input logic wb_rollback_en,
	input logic [THREAD_BITS-1:0] wb_rollback_thread,

	// To writeback
	output logic sc_instruction_valid,
	output logic [THREAD_BITS-1:0] sc_thread,
	output logic sc_has_dest,
	output logic sc_dest_is_vector,
	output logic [REG_BITS-1:0] sc_dest_reg,
	output logic [num_lanes*DATA_WIDTH-1:0] sc_result,
	output logic [num_lanes-1:0] sc_mask,
	output logic sc_rollback_en,
	output logic [DATA_WIDTH-1:0] sc_rollback_pc
);

	wire [num_lanes*DATA_WIDTH-1:0] lane_result;
	logic accept;
	logic branch_taken;

	// One ALU per lane
	for (genvar lane = 0; lane < num_lanes; lane++)
	begin : lane_alu
		logic [DATA_WIDTH-1:0] a;
		logic [DATA_WIDTH-1:0] b;
		logic [DATA_WIDTH-1:0] r;

		assign a = id_operand_a[lane*DATA_WIDTH +: DATA_WIDTH];
		assign b = id_operand_b[lane*DATA_WIDTH +: DATA_WIDTH];

		always_comb
		begin
			case (id_alu_op)
				ALU_ADD: r = a + b;
				ALU_SUB: r = a - b;
				ALU_AND: r = a & b;
				ALU_OR: r = a | b;
				ALU_XOR: r = a ^ b;
				// Shift amount from low 5 bits of B
				ALU_SHL: r = a << b[4:0];
				ALU_SHR: r = a >> b[4:0];
				ALU_MOVE: r = b;
				// Branch and unknown opcodes produce zero
				default: r = '0;
			endcase
		end

		assign lane_result[lane*DATA_WIDTH +: DATA_WIDTH] = r;
	end

	// Younger instruction of a rolling-back thread is dropped here
	assign accept = id_alu_valid && !(wb_rollback_en && wb_rollback_thread == id_thread);

	// Branch tests lane 0 of A
	assign branch_taken = id_alu_op == ALU_BNZ && id_operand_a[DATA_WIDTH-1:0] != '0;

	always_ff @(posedge clk, posedge reset)
	begin
		if (reset)
		begin
			sc_instruction_valid <= 1'b0;
			sc_rollback_en <= 1'b0;
			sc_thread <= '0;
			sc_has_dest <= 1'b0;
			sc_dest_is_vector <= 1'b0;
			sc_dest_reg <= '0;
			sc_result <= '0;
			sc_mask <= '0;
			sc_rollback_pc <= '0;
		end
		else
		begin
			sc_instruction_valid <= accept;
			sc_rollback_en <= accept && branch_taken;
			sc_thread <= id_thread;
			sc_has_dest <= id_has_dest;
			sc_dest_is_vector <= id_dest_is_vector;
			sc_dest_reg <= id_dest_reg;
			sc_result <= lane_result;
			sc_mask <= id_mask;
			// Target is lane 0 of B
			sc_rollback_pc <= id_operand_b[DATA_WIDTH-1:0];
		end
	end

endmodule

// File: hdl/instruction_decoder.sv
// Issue latch, instruction decode, path routing and rollback squash of new issues
`timescale 1ns/1ps

module instruction_decoder import backend_pkg::*; #(
	parameter int num_lanes = 4
) (
	input logic clk,
	input logic reset,

	// Issue side
	input logic issue_valid,
	input logic [THREAD_BITS-1:0] issue_thread,
	input instr_word_u issue_instr,
	input logic [num_lanes*DATA_WIDTH-1:0] issue_operand_a,
	input logic [num_lanes*DATA_WIDTH-1:0] issue_operand_b,
	input logic [num_lanes-1:0] issue_mask,

	// Rollback from writeback
	input logic wb_rollback_en,
	input logic [THREAD_BITS-1:0] wb_rollback_thread,

	// To execute and data stages
	output logic id_alu_valid,
	output logic id_mem_valid,
	output logic [THREAD_BITS-1:0] id_thread,
	output logic [3:0] id_alu_op,
	output logic [2:0] id_mem_op,
	output logic id_has_dest,
	output logic id_dest_is_vector,
	output logic [REG_BITS-1:0] id_dest_reg,
	output logic [num_lanes*DATA_WIDTH-1:0] id_operand_a,
	output logic [num_lanes*DATA_WIDTH-1:0] id_operand_b,
	output logic [num_lanes-1:0] id_mask,
	output logic [12:0] id_mem_offset
);

	logic is_mem;
	logic squash_issue;
	logic has_dest;
	logic dest_is_vector;
	logic [REG_BITS-1:0] dest_reg;

	// Memory flag sits in the same bit for both views
	assign is_mem = issue_instr.mem.is_mem;

	// Drop an issue of the thread being rolled back this cycle
	assign squash_issue = wb_rollback_en && wb_rollback_thread == issue_thread;

	// Destination fields differ in position between views
	always_comb
	begin
		if (is_mem)
		begin
			has_dest = 1'b1;
			dest_is_vector = issue_instr.mem.dest_is_vector;
			dest_reg = issue_instr.mem.dest_reg;
		end
		else
		begin
			// Only the branch writes nothing
			has_dest = issue_instr.alu.op != ALU_BNZ;
			dest_is_vector = issue_instr.alu.dest_is_vector;
			dest_reg = issue_instr.alu.dest_reg;
		end
	end

	always_ff @(posedge clk, posedge reset)
	begin
		if (reset)
		begin
			id_alu_valid <= 1'b0;
			id_mem_valid <= 1'b0;
			id_thread <= '0;
			id_alu_op <= '0;
			id_mem_op <= '0;
			id_has_dest <= 1'b0;
			id_dest_is_vector <= 1'b0;
			id_dest_reg <= '0;
			id_operand_a <= '0;
			id_operand_b <= '0;
			id_mask <= '0;
			id_mem_offset <= '0;
		end
		else
		begin
			// Route to exactly one path
			id_alu_valid <= issue_valid && !squash_issue && !is_mem;
			id_mem_valid <= issue_valid && !squash_issue && is_mem;
			id_thread <= issue_thread;
			id_alu_op <= issue_instr.alu.op;
			id_mem_op <= issue_instr.mem.op;
			id_has_dest <= has_dest;
			id_dest_is_vector <= dest_is_vector;
			id_dest_reg <= dest_reg;
			id_operand_a <= issue_operand_a;
			id_operand_b <= issue_operand_b;
			id_mask <= issue_mask;
			id_mem_offset <= issue_instr.mem.offset;
		end
	end

endmodule

// File: hdl/backend_pkg.sv
// Backend widths, register and opcode constants, instruction word union
package backend_pkg;

	// Width of one vector lane and of a scalar
	localparam int DATA_WIDTH = 32;

	// Four hardware threads
	localparam int THREAD_BITS = 2;

	// Register index width
	localparam int REG_BITS = 5;

	// Program counter register, a write to it redirects the thread
	localparam logic [REG_BITS-1:0] REG_PC = 5'd31;

	// Arithmetic opcodes
	localparam logic [3:0] ALU_ADD = 4'd0;
	localparam logic [3:0] ALU_SUB = 4'd1;
	localparam logic [3:0] ALU_AND = 4'd2;
	localparam logic [3:0] ALU_OR = 4'd3;
	localparam logic [3:0] ALU_XOR = 4'd4;
	localparam logic [3:0] ALU_SHL = 4'd5;
	localparam logic [3:0] ALU_SHR = 4'd6;
	// Passes operand B through
	localparam logic [3:0] ALU_MOVE = 4'd7;
	// Branch if lane 0 of A nonzero, no destination
	localparam logic [3:0] ALU_BNZ = 4'd8;

	// Load kinds
	localparam logic [2:0] MEM_B = 3'd0;
	localparam logic [2:0] MEM_BX = 3'd1;
	localparam logic [2:0] MEM_S = 3'd2;
	localparam logic [2:0] MEM_SX = 3'd3;
	localparam logic [2:0] MEM_W = 3'd4;
	// Whole cache line into a vector register
	localparam logic [2:0] MEM_BLOCK = 3'd5;

	// Instruction word, bit 31 picks the view
	typedef union packed {
		struct packed {
			logic is_mem;
			logic [3:0] op;
			logic dest_is_vector;
			logic [REG_BITS-1:0] dest_reg;
			logic [20:0] reserved;
		} alu;
		struct packed {
			logic is_mem;
			logic [2:0] op;
			logic dest_is_vector;
			logic [REG_BITS-1:0] dest_reg;
			logic [8:0] reserved;
			// Byte offset added to lane 0 of operand A
			logic signed [12:0] offset;
		} mem;
	} instr_word_u;

endpackage
